/* hdl/video_pkg.sv */
`default_nettype none

package video_pkg;

    // Counter types for the raster position
    typedef logic [5:0] hcnt_t;
    typedef logic [4:0] vcnt_t;

    // Raster size in pixels and lines
    localparam hcnt_t H_TOTAL  = 6'd32;
    localparam hcnt_t H_ACTIVE = 6'd24;
    localparam vcnt_t V_TOTAL  = 5'd16;
    localparam vcnt_t V_ACTIVE = 5'd12;

    // Pixel clock enable divider
    localparam int PXL_DIV   = 2;
    localparam int PXL_DIV_W = $clog2(PXL_DIV);

    // Colour depth and palette size
    localparam int COL_W  = 4;
    localparam int PAL_AW = 8;

    typedef logic [PAL_AW-1:0] col_idx_t;

    // Palette word, odd bank in the upper byte
    typedef struct packed {
        logic [7:0] odd;
        logic [7:0] even;
    } col_word_t;

endpackage

`default_nettype wire

/* hdl/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    // Byte address, bit 0 picks the bank
    localparam int WB_AW = 9;
    localparam int WB_DW = 8;

    typedef logic [WB_AW-1:0] wb_adr_t;
    typedef logic [WB_DW-1:0] wb_dat_t;

    // Palette slave states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RD_WAIT,
        ST_ACK
    } fsm_state_t;

endpackage

`default_nettype wire

/* hdl/video_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module video_timer
    import video_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    output logic  pxl_cen,
    output hcnt_t hcnt,
    output vcnt_t vcnt,
    output logic  pre_lhbl,
    output logic  pre_lvbl
);

    logic [PXL_DIV_W-1:0] div_cnt;
    logic                 h_last;
    logic                 v_last;

    // Divide clk down to the pixel rate
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (pxl_cen) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Enable on the last cycle of each pixel
    assign pxl_cen = div_cnt == PXL_DIV_W'(PXL_DIV - 1);

    // End of line and end of frame
    assign h_last = hcnt == H_TOTAL - 1'b1;
    assign v_last = vcnt == V_TOTAL - 1'b1;

    // Raster counters, vertical steps at each line wrap
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (pxl_cen) begin
            if (h_last) begin
                hcnt <= '0;
                vcnt <= v_last ? '0 : vcnt + 1'b1;
            end else begin
                hcnt <= hcnt + 1'b1;
            end
        end
    end

    // Visible area decode
    assign pre_lhbl = hcnt < H_ACTIVE;
    assign pre_lvbl = vcnt < V_ACTIVE;

endmodule

`default_nettype wire

/* hdl/wb_pal_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_pal_fsm
    import bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    wb_cyc,
    input  logic    wb_stb,
    input  logic    wb_we,
    input  wb_adr_t wb_adr,
    input  wb_dat_t wb_dat_w,
    output wb_dat_t wb_dat_r,
    output logic    wb_ack,
    output logic    pal_we,
    output wb_adr_t pal_adr,
    output wb_dat_t pal_wdata,
    input  wb_dat_t pal_rdata
);

    fsm_state_t state;
    wb_adr_t    adr_r;
    logic       we_r;
    logic       req;

    assign req = wb_cyc && wb_stb;

    // Control path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            we_r  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        we_r  <= wb_we;
                        state <= wb_we ? ST_ACK : ST_RD_WAIT;
                    end
                end
                ST_RD_WAIT: state <= ST_ACK;
                // Single cycle ack, then straight back to idle
                default: begin
                    we_r  <= 1'b0;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Request payload, captured with the request
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req) begin
            adr_r     <= wb_adr;
            pal_wdata <= wb_dat_w;
        end
        // Bank output is valid one cycle after the address
        if (state == ST_RD_WAIT) begin
            wb_dat_r <= pal_rdata;
        end
    end

    // Idle presents the live address so the RAM read starts with the request
    assign pal_adr = (state == ST_IDLE) ? wb_adr : adr_r;
    assign pal_we  = (state == ST_ACK) && we_r;
    assign wb_ack  = state == ST_ACK;

endmodule

`default_nettype wire

/* hdl/pal_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module pal_ram
    import video_pkg::*;
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     we,
    input  col_idx_t cpu_adr,
    input  wb_dat_t  cpu_din,
    output wb_dat_t  cpu_dout,
    input  col_idx_t vid_adr,
    output wb_dat_t  vid_dout
);

    wb_dat_t mem [2**PAL_AW];

    // CPU port, read returns the old byte on a write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[cpu_adr] <= cpu_din;
        end
        cpu_dout <= mem[cpu_adr];
    end

    // Video lookup port
    always_ff @(posedge clk) begin
        vid_dout <= mem[vid_adr];
    end

endmodule

`default_nettype wire

/* hdl/blank_dly.sv */
`timescale 1ns/1ps
`default_nettype none

module blank_dly
    import video_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      pxl_cen,
    input  logic      pre_lhbl,
    input  logic      pre_lvbl,
    input  col_word_t rgb_in,
    output logic      lhbl,
    output logic      lvbl,
    output col_word_t rgb_out
);

    logic visible;

    // Colour only passes inside the active area
    assign visible = pre_lhbl && pre_lvbl;

    // One pixel delay keeps colour aligned with blanking
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lhbl    <= 1'b0;
            lvbl    <= 1'b0;
            rgb_out <= '0;
        end else if (pxl_cen) begin
            lhbl    <= pre_lhbl;
            lvbl    <= pre_lvbl;
            // Blank forces black
            rgb_out <= visible ? rgb_in : '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/colmix.sv */
`timescale 1ns/1ps
`default_nettype none

module colmix
    import video_pkg::*;
    import bus_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             pxl_cen,
    input  logic             pre_lhbl,
    input  logic             pre_lvbl,
    input  col_idx_t         col_addr,
    input  logic             black_n,
    input  logic             pal_we,
    input  wb_adr_t          pal_adr,
    input  wb_dat_t          pal_wdata,
    output wb_dat_t          pal_rdata,
    output logic             lhbl,
    output logic             lvbl,
    output logic [COL_W-1:0] red,
    output logic [COL_W-1:0] green,
    output logic [COL_W-1:0] blue
);

    logic      even_we;
    logic      odd_we;
    col_idx_t  cpu_idx;
    wb_dat_t   cpu_even;
    wb_dat_t   cpu_odd;
    wb_dat_t   vid_even;
    wb_dat_t   vid_odd;
    col_word_t pal_word;
    col_word_t col_in;
    col_word_t col_out;

    // Byte address to bank and index
    assign cpu_idx = pal_adr[WB_AW-1:1];
    assign even_we = pal_we && !pal_adr[0];
    assign odd_we  = pal_we && pal_adr[0];

    // Readback byte from the addressed bank
    assign pal_rdata = pal_adr[0] ? cpu_odd : cpu_even;

    pal_ram i_pal_even (
        .clk      (clk),
        .we       (even_we),
        .cpu_adr  (cpu_idx),
        .cpu_din  (pal_wdata),
        .cpu_dout (cpu_even),
        .vid_adr  (col_addr),
        .vid_dout (vid_even)
    );

    pal_ram i_pal_odd (
        .clk      (clk),
        .we       (odd_we),
        .cpu_adr  (cpu_idx),
        .cpu_din  (pal_wdata),
        .cpu_dout (cpu_odd),
        .vid_adr  (col_addr),
        .vid_dout (vid_odd)
    );

    // Both banks looked up with the same index
    assign pal_word = {vid_odd, vid_even};

    // Global black mask
    assign col_in = black_n ? pal_word : '0;

    blank_dly i_blank_dly (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .pre_lhbl (pre_lhbl),
        .pre_lvbl (pre_lvbl),
        .rgb_in   (col_in),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .rgb_out  (col_out)
    );

    // Channel split, low nibble of odd byte unused
    assign red   = col_out.even[COL_W +: COL_W];
    assign green = col_out.even[0 +: COL_W];
    assign blue  = col_out.odd[COL_W +: COL_W];

endmodule

`default_nettype wire

/* hdl/video_top.sv */
`timescale 1ns/1ps
`default_nettype none

module video_top
    import video_pkg::*;
    import bus_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    // Wishbone slave
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  wb_adr_t          wb_adr,
    input  wb_dat_t          wb_dat_w,
    output wb_dat_t          wb_dat_r,
    output logic             wb_ack,
    // Pixel index from the tile stage
    input  col_idx_t         col_addr,
    input  logic             black_n,
    // Video out
    output logic             lhbl,
    output logic             lvbl,
    output hcnt_t            hcnt,
    output vcnt_t            vcnt,
    output logic [COL_W-1:0] red,
    output logic [COL_W-1:0] green,
    output logic [COL_W-1:0] blue
);

    logic    pxl_cen;
    logic    pre_lhbl;
    logic    pre_lvbl;
    logic    pal_we;
    wb_adr_t pal_adr;
    wb_dat_t pal_wdata;
    wb_dat_t pal_rdata;

    // Raster timing
    video_timer i_video_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .hcnt     (hcnt),
        .vcnt     (vcnt),
        .pre_lhbl (pre_lhbl),
        .pre_lvbl (pre_lvbl)
    );

    // CPU access to the palette
    wb_pal_fsm i_wb_pal_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .pal_we    (pal_we),
        .pal_adr   (pal_adr),
        .pal_wdata (pal_wdata),
        .pal_rdata (pal_rdata)
    );

    // Palette lookup and blanking
    colmix i_colmix (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .pre_lhbl  (pre_lhbl),
        .pre_lvbl  (pre_lvbl),
        .col_addr  (col_addr),
        .black_n   (black_n),
        .pal_we    (pal_we),
        .pal_adr   (pal_adr),
        .pal_wdata (pal_wdata),
        .pal_rdata (pal_rdata),
        .lhbl      (lhbl),
        .lvbl      (lvbl),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

endmodule

`default_nettype wire

/* testbench/tb_video_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_video_top
    import video_pkg::*;
    import bus_pkg::*;
();

    localparam int CLK_HALF    = 10;
    localparam int BUS_TIMEOUT = 16;
    localparam int FRAME_CLKS  = int'(H_TOTAL) * int'(V_TOTAL) * PXL_DIV;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    wb_adr_t          wb_adr;
    wb_dat_t          wb_dat_w;
    wb_dat_t          wb_dat_r;
    logic             wb_ack;
    col_idx_t         col_addr;
    logic             black_n;
    logic             lhbl;
    logic             lvbl;
    hcnt_t            hcnt;
    vcnt_t            vcnt;
    logic [COL_W-1:0] red;
    logic [COL_W-1:0] green;
    logic [COL_W-1:0] blue;

    // Palette model indexed by byte address
    logic [7:0]       pal_model [512];
    int               seed;
    int               err_val;
    int               err_other;
    int               frames_done;
    int               lh_run;
    int               lv_run;
    logic             pix_rand;
    logic             pix_chk_en;

    // Raster model state
    int               m_div;
    int               m_h;
    int               m_v;
    logic             m_cen;
    logic             m_lhbl;
    logic             m_lvbl;
    logic             m_after_cen;
    logic             m_chk;
    logic             pix_phase;
    logic [3:0]       m_exp_r;
    logic [3:0]       m_exp_g;
    logic [3:0]       m_exp_b;

    always #CLK_HALF clk = !clk;

    video_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .col_addr (col_addr),
        .black_n  (black_n),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .hcnt     (hcnt),
        .vcnt     (vcnt),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

    task automatic check_value(input string name, input int exp, input int act);
        assert (act == exp) else begin
            err_val++;
            $display("Fail at %0t: %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    task automatic check_idle_outputs();
        check_value("wb_ack", 0, int'(wb_ack));
        check_value("lhbl", 0, int'(lhbl));
        check_value("lvbl", 0, int'(lvbl));
        check_value("red", 0, int'(red));
        check_value("green", 0, int'(green));
        check_value("blue", 0, int'(blue));
    endtask

    // One bus cycle with ack latency in clocks from the drive
    task automatic bus_access(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                              output int lat);
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!wb_ack && lat < BUS_TIMEOUT);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!wb_ack) begin
            err_other++;
            lat = -1;
            $display("Bus access to address %h was never acknowledged", adr);
        end
    endtask

    task automatic bus_write(input wb_adr_t adr, input wb_dat_t dat);
        int lat;
        bus_access(1'b1, adr, dat, lat);
        if (lat >= 0) begin
            check_value("write wb_ack latency", 1, lat);
        end
    endtask

    task automatic bus_read_check(input wb_adr_t adr);
        int lat;
        bus_access(1'b0, adr, 8'h00, lat);
        if (lat >= 0) begin
            check_value("read wb_ack latency", 2, lat);
            check_value("wb_dat_r", int'(pal_model[adr]), int'(wb_dat_r));
        end
    endtask

    task automatic wait_frames(input int count);
        int target;
        int n;
        target = frames_done + count;
        n = 0;
        while (frames_done < target && n < (count + 1) * FRAME_CLKS) begin
            @(negedge clk);
            n++;
        end
        if (frames_done < target) begin
            err_other++;
            $display("Timed out waiting for %0d video frames", count);
        end
    endtask

    // Raster and colour expectation stepped on the model pixel enable
    assign m_cen = m_div == PXL_DIV - 1;

    always @(posedge clk) begin
        if (!rst_n) begin
            m_div       <= 0;
            m_h         <= 0;
            m_v         <= 0;
            m_lhbl      <= 1'b0;
            m_lvbl      <= 1'b0;
            m_after_cen <= 1'b0;
            m_chk       <= 1'b0;
            pix_phase   <= 1'b0;
        end else begin
            m_after_cen <= m_cen;
            m_chk       <= m_cen && pix_phase;
            if (m_cen) begin
                m_div     <= 0;
                pix_phase <= !pix_phase;
                m_lhbl    <= m_h < int'(H_ACTIVE);
                m_lvbl    <= m_v < int'(V_ACTIVE);
                // Colour loaded at this pixel
                if (m_h < int'(H_ACTIVE) && m_v < int'(V_ACTIVE) && black_n) begin
                    m_exp_r <= pal_model[{col_addr, 1'b0}][7:4];
                    m_exp_g <= pal_model[{col_addr, 1'b0}][3:0];
                    m_exp_b <= pal_model[{col_addr, 1'b1}][7:4];
                end else begin
                    m_exp_r <= 4'h0;
                    m_exp_g <= 4'h0;
                    m_exp_b <= 4'h0;
                end
                if (m_h == int'(H_TOTAL) - 1) begin
                    m_h <= 0;
                    m_v <= (m_v == int'(V_TOTAL) - 1) ? 0 : m_v + 1;
                end else begin
                    m_h <= m_h + 1;
                end
            end else begin
                m_div <= m_div + 1;
            end
        end
    end

    // Output checks where everything is stable
    always @(negedge clk) begin
        if (rst_n) begin
            check_value("hcnt", m_h, int'(hcnt));
            check_value("vcnt", m_v, int'(vcnt));
            check_value("lhbl", int'(m_lhbl), int'(lhbl));
            check_value("lvbl", int'(m_lvbl), int'(lvbl));
            if (m_chk && pix_chk_en) begin
                check_value("red", int'(m_exp_r), int'(red));
                check_value("green", int'(m_exp_g), int'(green));
                check_value("blue", int'(m_exp_b), int'(blue));
            end
            // Visible pixels per line, visible lines per frame
            if (m_after_cen) begin
                lh_run = lh_run + int'(lhbl);
                if (m_h == 0) begin
                    check_value("lhbl pixels per line", int'(H_ACTIVE), lh_run);
                    lh_run = 0;
                    lv_run = lv_run + int'(lvbl);
                    if (m_v == 0) begin
                        check_value("lvbl lines per frame", int'(V_ACTIVE), lv_run);
                        lv_run = 0;
                        frames_done++;
                    end
                end
            end
        end else begin
            lh_run = 0;
            lv_run = 0;
        end
    end

    // New index only before the first pixel of a pair
    initial begin
        col_addr = '0;
        forever begin
            @(negedge clk);
            if (rst_n && m_cen && !pix_phase) begin
                col_addr = pix_rand ? 8'($random(seed)) : 8'h00;
            end
        end
    end

    a_blank_black: assert property (@(negedge clk) disable iff (!rst_n)
        (!lhbl || !lvbl) |-> (red == 4'h0 && green == 4'h0 && blue == 4'h0))
    else begin
        err_val++;
        $display("Fail at %0t: rgb in blanking expected 000 got %h%h%h", $time, red, green, blue);
    end

    a_ack_single: assert property (@(negedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
    else begin
        err_val++;
        $display("Fail at %0t: wb_ack after ack cycle expected 0 got %0d", $time, wb_ack);
    end

    initial begin
        int      i;
        wb_adr_t adr;
        seed        = 26154;
        err_val     = 0;
        err_other   = 0;
        frames_done = 0;
        lh_run      = 0;
        lv_run      = 0;
        rst_n       = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        black_n     = 1'b1;
        pix_rand    = 1'b0;
        pix_chk_en  = 1'b0;
        for (i = 0; i < 512; i++) begin
            pal_model[i] = 8'($random(seed));
        end

        // Reset for three cycles, then one edge out of reset
        repeat (3) begin
            @(negedge clk);
            check_idle_outputs();
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs();

        // Fill both banks, read back in a scrambled order
        for (i = 0; i < 512; i++) begin
            bus_write(9'(i), pal_model[i]);
        end
        for (i = 0; i < 512; i++) begin
            bus_read_check(9'((i * 37) % 512));
        end

        // Random indices through the lookup
        pix_chk_en = 1'b1;
        pix_rand   = 1'b1;
        wait_frames(2);

        // Global black mask
        black_n = 1'b0;
        wait_frames(1);
        black_n = 1'b1;

        // Index 0 on screen while other entries change
        pix_rand = 1'b0;
        wait_frames(1);
        for (i = 0; i < 64; i++) begin
            adr = 9'(2 + $unsigned($random(seed)) % 510);
            pal_model[adr] = 8'($random(seed));
            bus_write(adr, pal_model[adr]);
            bus_read_check(adr);
        end
        wait_frames(1);

        $display("Errors: %0d value mismatches, %0d other failures", err_val, err_other);
        if (err_val == 0 && err_other == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
hdl/video_pkg.sv
hdl/bus_pkg.sv
hdl/video_timer.sv
hdl/wb_pal_fsm.sv
hdl/pal_ram.sv
hdl/blank_dly.sv
hdl/colmix.sv
hdl/video_top.sv
testbench/tb_video_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_video_top -f project.f -Mdir obj_dir \
    && ./obj_dir/Vtb_video_top > sim.log 2>&1 \
    || { echo "Build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "Test passed" sim.log && echo "Simulation PASS" || { echo "Simulation FAIL"; exit 1; }
